/* include/blaster_cfg.svh */
`ifndef BLASTER_CFG_SVH
`define BLASTER_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Keypad scan
////////////////////////////////////////////////////////////////////////////

`define SCAN_DIV_BITS 12 // 1024 cycles per row, 4096 per frame
`define SCAN_SAMPLE_OFFSET 1008 // Column sample point in a row phase

////////////////////////////////////////////////////////////////////////////
// Fire pulse train
////////////////////////////////////////////////////////////////////////////

`define TRIG_PERIOD_BITS 12 // Trigger tick every 4096 cycles
`define PULSE_MIN 48 // Min on time, also min off time
`define PULSE_MAX 768 // Max on time
`define PULSE_COUNT 3 // Pulses per fire request

// Coil current thresholds in ADC counts
`define I_HIGH 430 // About 2 A plus margin
`define I_LOW 390 // About 2 A minus margin
`define SAMPLE_W 12

////////////////////////////////////////////////////////////////////////////
// Speaker
////////////////////////////////////////////////////////////////////////////

`define TONE_W 16

`endif

/* source/blaster_pkg.sv */
`include "blaster_cfg.svh"

package blaster_pkg;

	// Keypad codes, bit 4 set while a key is held
	typedef enum logic [4:0] {
		KEY_NONE    = 5'h00,
		KEY_FIRE    = 5'h10,
		KEY_TONE1   = 5'h11,
		KEY_TONE2   = 5'h12,
		KEY_TONE3   = 5'h13,
		KEY_TONE4   = 5'h14,
		KEY_TONE5   = 5'h15,
		KEY_TONE6   = 5'h16,
		KEY_TONE7   = 5'h17,
		KEY_TONE8   = 5'h18,
		KEY_RESMEAS = 5'h19, // Decoded, no action
		KEY_CHARGE  = 5'h1A,
		KEY_DUMP    = 5'h1B
	} key_code_t;

	typedef enum logic [1:0] {
		PS_IDLE = 2'd0,
		PS_ON   = 2'd1,
		PS_OFF  = 2'd2
	} pulse_state_t;

	// Half period reload for each tone key, zero means silent
	function automatic logic [`TONE_W-1:0] tone_reload(input key_code_t k);
		logic [`TONE_W-1:0] r;
		case (k)
			KEY_TONE1: r = 16'h2CCA;
			KEY_TONE2: r = 16'h27E7;
			KEY_TONE3: r = 16'h238D;
			KEY_TONE4: r = 16'h218E;
			KEY_TONE5: r = 16'h1DE5;
			KEY_TONE6: r = 16'h1AA2;
			KEY_TONE7: r = 16'h17BA;
			KEY_TONE8: r = 16'h1665;
			default:   r = '0;
		endcase
		return r;
	endfunction

endpackage

/* source/blaster_top.sv */
`include "blaster_cfg.svh"

module blaster_top (
	input  logic                 clk,
	input  logic                 reset,

	// Panel inputs
	input  logic                 fire_button,
	input  logic                 lt3420_done,
	input  logic                 cont_n,
	input  logic [2:0]           iset, // Active low switches

	// Coil current sample
	input  logic [`SAMPLE_W-1:0] coil_current,

	// Keypad matrix
	input  logic [6:0]           keypad_in,
	output logic [6:0]           keypad_out,

	// High voltage and panel outputs
	output logic                 pwm,
	output logic                 speaker,
	output logic                 speaker_n,
	output logic                 arm_led_n,
	output logic                 cont_led_n,
	output logic                 lt3420_charge,
	output logic                 dump
);

	blaster_pkg::key_code_t key; // Shared by both consumers

	////////////////////////////////////////////////////////////////////////////
	// Decode, execute, result
	////////////////////////////////////////////////////////////////////////////

	key_scan u_key_scan (
		.clk        (clk),
		.reset      (reset),
		.keypad_in  (keypad_in),
		.keypad_out (keypad_out),
		.key        (key)
	);

	fire_pulse_gen u_fire_pulse_gen (
		.clk          (clk),
		.reset        (reset),
		.fire_button  (fire_button),
		.key          (key),
		.coil_current (coil_current),
		.pwm          (pwm)
	);

	panel_driver u_panel_driver (
		.clk           (clk),
		.reset         (reset),
		.fire_button   (fire_button),
		.lt3420_done   (lt3420_done),
		.cont_n        (cont_n),
		.iset          (iset),
		.key           (key),
		.speaker       (speaker),
		.speaker_n     (speaker_n),
		.arm_led_n     (arm_led_n),
		.cont_led_n    (cont_led_n),
		.lt3420_charge (lt3420_charge),
		.dump          (dump)
	);

endmodule

/* source/fire_pulse_gen.sv */
`include "blaster_cfg.svh"

module fire_pulse_gen (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   fire_button,
	input  blaster_pkg::key_code_t key,
	input  logic [`SAMPLE_W-1:0]   coil_current,
	output logic                   pwm
);

	localparam int SW = `SAMPLE_W;
	localparam int WIDTH_W = $clog2(`PULSE_MAX + 1);
	localparam int COUNT_W = $clog2(`PULSE_COUNT + 1);
	localparam logic [WIDTH_W-1:0] MIN_W = WIDTH_W'(`PULSE_MIN);
	localparam logic [WIDTH_W-1:0] MAX_W = WIDTH_W'(`PULSE_MAX);
	localparam logic [COUNT_W-1:0] NUM_PULSES = COUNT_W'(`PULSE_COUNT);
	localparam logic [SW-1:0] CUR_HIGH = SW'(`I_HIGH);
	localparam logic [SW-1:0] CUR_LOW = SW'(`I_LOW);

	logic [`TRIG_PERIOD_BITS-1:0] trig_cnt;
	logic trig_tick;
	logic fire_req;
	blaster_pkg::pulse_state_t state;
	logic [WIDTH_W-1:0] width; // Cycles into the current on or off time
	logic [COUNT_W-1:0] remaining; // Pulses left, the running one included

	assign trig_tick = (trig_cnt == '0);
	assign fire_req = fire_button || (key == blaster_pkg::KEY_FIRE);

	// Free running trigger period
	always_ff @(posedge clk) begin
		if (reset)
			trig_cnt <= '0;
		else
			trig_cnt <= trig_cnt + 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Current limited pulse FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= blaster_pkg::PS_IDLE;
			pwm <= 1'b0;
			width <= '0;
			remaining <= '0;
		end else begin
			case (state)
				blaster_pkg::PS_IDLE: begin
					if (fire_req && trig_tick) begin
						state <= blaster_pkg::PS_ON;
						pwm <= 1'b1;
						width <= 1;
						remaining <= NUM_PULSES;
					end
				end

				blaster_pkg::PS_ON: begin
					if (width < MIN_W) begin
						width <= width + 1'b1; // Hold through min width
					end else if (width >= MAX_W || coil_current > CUR_HIGH) begin
						pwm <= 1'b0;
						width <= '0;
						remaining <= remaining - 1'b1;
						if (remaining == 1)
							state <= blaster_pkg::PS_IDLE; // Last pulse done
						else
							state <= blaster_pkg::PS_OFF;
					end else begin
						width <= width + 1'b1;
					end
				end

				blaster_pkg::PS_OFF: begin
					if (width < MIN_W) begin
						width <= width + 1'b1;
					end else if (coil_current < CUR_LOW) begin
						// Coil has decayed, start next pulse
						state <= blaster_pkg::PS_ON;
						pwm <= 1'b1;
						width <= 1;
					end
				end

				default: begin
					state <= blaster_pkg::PS_IDLE;
					pwm <= 1'b0;
					width <= '0;
					remaining <= '0;
				end
			endcase
		end
	end

endmodule

/* source/key_scan.sv */
`include "blaster_cfg.svh"

module key_scan (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [6:0]             keypad_in,
	output logic [6:0]             keypad_out,
	output blaster_pkg::key_code_t key
);

	localparam int DIV_W = `SCAN_DIV_BITS;
	localparam logic [DIV_W-3:0] SAMPLE_AT = (DIV_W-2)'(`SCAN_SAMPLE_OFFSET);

	logic [DIV_W-1:0] div;
	logic [1:0] phase;
	logic [2:0] col_low; // Active high copy of the column pins
	logic [3:0] row_drive; // Active high copy of the driven rows
	logic [2:0] col;
	logic [3:0] row;
	logic pressed; // Some key seen in this frame
	blaster_pkg::key_code_t next_key;

	assign phase = div[DIV_W-1 -: 2];
	assign col_low = {~keypad_in[2], ~keypad_in[0], ~keypad_in[4]};
	assign row_drive = {~keypad_out[3], ~keypad_out[5], ~keypad_out[6], ~keypad_out[1]};

	////////////////////////////////////////////////////////////////////////////
	// Row drive
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			div <= '0;
			keypad_out <= 7'h7F; // All rows idle
		end else begin
			div <= div + 1'b1;
			keypad_out[1] <= (phase != 2'd0); // Row 0
			keypad_out[6] <= (phase != 2'd1); // Row 1
			keypad_out[5] <= (phase != 2'd2); // Row 2
			keypad_out[3] <= (phase != 2'd3); // Row 3
			// Column sense pins stay high
			keypad_out[0] <= 1'b1;
			keypad_out[2] <= 1'b1;
			keypad_out[4] <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Column capture
	////////////////////////////////////////////////////////////////////////////

	// Latch holds until a whole frame goes by with nothing pressed
	always_ff @(posedge clk) begin
		if (reset) begin
			pressed <= 1'b0;
			col <= '0;
			row <= '0;
		end else if (div == '0) begin
			pressed <= 1'b0; // New frame
		end else if (div == '1 && !pressed) begin
			col <= '0;
			row <= '0;
		end else if (div[DIV_W-3:0] == SAMPLE_AT && col_low != 3'b000) begin
			pressed <= 1'b1;
			col <= col_low;
			row <= row_drive;
		end
	end

	// Priority decode, col0 first
	always_comb begin
		if (col[0] && row[0])
			next_key = blaster_pkg::KEY_TONE3;
		else if (col[0] && row[1])
			next_key = blaster_pkg::KEY_TONE6;
		else if (col[0] && row[2])
			next_key = blaster_pkg::KEY_RESMEAS;
		else if (col[0] && row[3])
			next_key = blaster_pkg::KEY_DUMP;
		else if (col[1] && row[0])
			next_key = blaster_pkg::KEY_TONE2;
		else if (col[1] && row[1])
			next_key = blaster_pkg::KEY_TONE5;
		else if (col[1] && row[2])
			next_key = blaster_pkg::KEY_TONE8;
		else if (col[1] && row[3])
			next_key = blaster_pkg::KEY_FIRE;
		else if (col[2] && row[0])
			next_key = blaster_pkg::KEY_TONE1;
		else if (col[2] && row[1])
			next_key = blaster_pkg::KEY_TONE4;
		else if (col[2] && row[2])
			next_key = blaster_pkg::KEY_TONE7;
		else if (col[2] && row[3])
			next_key = blaster_pkg::KEY_CHARGE;
		else
			next_key = blaster_pkg::KEY_NONE;
	end

	always_ff @(posedge clk) begin
		if (reset)
			key <= blaster_pkg::KEY_NONE;
		else
			key <= next_key;
	end

endmodule

/* source/panel_driver.sv */
`include "blaster_cfg.svh"

module panel_driver (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   fire_button,
	input  logic                   lt3420_done,
	input  logic                   cont_n,
	input  logic [2:0]             iset, // Active low switches
	input  blaster_pkg::key_code_t key,
	output logic                   speaker,
	output logic                   speaker_n,
	output logic                   arm_led_n,
	output logic                   cont_led_n,
	output logic                   lt3420_charge,
	output logic                   dump
);

	logic [`TONE_W-1:0] tone_cnt;
	logic [`TONE_W-1:0] reload;
	logic spk_phase;
	logic spk_en; // Last reload was a real tone

	////////////////////////////////////////////////////////////////////////////
	// Tone generator
	////////////////////////////////////////////////////////////////////////////

	assign reload = blaster_pkg::tone_reload(key);

	// Half period is reload+1 cycles
	always_ff @(posedge clk) begin
		if (reset) begin
			tone_cnt <= '0;
			spk_phase <= 1'b0;
			spk_en <= 1'b0;
		end else if (tone_cnt == '0) begin
			tone_cnt <= reload;
			spk_phase <= !spk_phase;
			spk_en <= (reload != '0);
		end else begin
			tone_cnt <= tone_cnt - 1'b1;
		end
	end

	// Differential drive doubles the swing
	assign speaker = spk_phase & spk_en;
	assign speaker_n = !speaker;

	////////////////////////////////////////////////////////////////////////////
	// Level outputs
	////////////////////////////////////////////////////////////////////////////

	// Switch or keypad can dump the cap
	assign dump = !iset[1] || (key == blaster_pkg::KEY_DUMP);
	assign lt3420_charge = !iset[2] || (key == blaster_pkg::KEY_CHARGE);

	// LEDs are active low
	assign arm_led_n = !(fire_button || lt3420_done);
	assign cont_led_n = !(iset[1] && cont_n); // Lit on open circuit, dump off

endmodule

/* tests/blaster_tb.sv */
`include "blaster_cfg.svh"

module blaster_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int FRAME = 1 << `SCAN_DIV_BITS;
	localparam int KEY_TIMEOUT = 3 * FRAME;
	localparam int TRIG = 1 << `TRIG_PERIOD_BITS;
	localparam int TRIP = 100; // Coil model crosses I_HIGH this far into a pulse
	localparam int NEVER_TRIP = 1 << 20;
	localparam int QUIET = 16'h2CCA + 101; // Longer than any half period
	localparam int SEL_PWM = 0;
	localparam int SEL_SPEAKER = 1;
	localparam int SEL_DUMP = 2;
	localparam int SEL_CHARGE = 3;

	logic clk;
	logic reset;
	logic fire_button;
	logic lt3420_done;
	logic cont_n;
	logic [2:0] iset;
	logic [`SAMPLE_W-1:0] coil_current;
	logic [6:0] keypad_in;
	logic [6:0] keypad_out;
	logic pwm;
	logic speaker;
	logic speaker_n;
	logic arm_led_n;
	logic cont_led_n;
	logic lt3420_charge;
	logic dump;

	blaster_pkg::key_code_t pressed_key;
	logic current_limit; // Coil model on
	logic level_check_en;
	logic [3:0] exp_levels;
	int high_cycles;
	int errors;
	int checks;
	int unsigned rng_state;
	string test_name;

	tb_clock clock_gen (.clk(clk));

	keypad_model keypad (
		.key        (pressed_key),
		.keypad_out (keypad_out),
		.keypad_in  (keypad_in)
	);

	blaster_top UUT (
		.clk           (clk),
		.reset         (reset),
		.fire_button   (fire_button),
		.lt3420_done   (lt3420_done),
		.cont_n        (cont_n),
		.iset          (iset),
		.coil_current  (coil_current),
		.keypad_in     (keypad_in),
		.keypad_out    (keypad_out),
		.pwm           (pwm),
		.speaker       (speaker),
		.speaker_n     (speaker_n),
		.arm_led_n     (arm_led_n),
		.cont_led_n    (cont_led_n),
		.lt3420_charge (lt3420_charge),
		.dump          (dump)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic int unsigned lcg_next();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state >> 16;
	endfunction

	// {dump, lt3420_charge, arm_led_n, cont_led_n}
	function automatic logic [3:0] expected_levels(input logic [2:0] sw, input logic cont,
			input logic done, input logic fire, input blaster_pkg::key_code_t k);
		logic [3:0] lv;
		lv[3] = !sw[1] || (k == blaster_pkg::KEY_DUMP);
		lv[2] = !sw[2] || (k == blaster_pkg::KEY_CHARGE);
		lv[1] = !(fire || done);
		lv[0] = !(sw[1] && cont); // Lit only with dump off and open coil
		return lv;
	endfunction

	// Tone keys 1 to 8 in order
	function automatic int expected_half_period(input blaster_pkg::key_code_t k);
		int reload;
		case (k)
			blaster_pkg::KEY_TONE1: reload = 'h2CCA;
			blaster_pkg::KEY_TONE2: reload = 'h27E7;
			blaster_pkg::KEY_TONE3: reload = 'h238D;
			blaster_pkg::KEY_TONE4: reload = 'h218E;
			blaster_pkg::KEY_TONE5: reload = 'h1DE5;
			blaster_pkg::KEY_TONE6: reload = 'h1AA2;
			blaster_pkg::KEY_TONE7: reload = 'h17BA;
			blaster_pkg::KEY_TONE8: reload = 'h1665;
			default:                reload = 0;
		endcase
		return reload + 1;
	endfunction

	// On time when the current crosses I_HIGH trip cycles after the rise
	function automatic int expected_width(input int trip);
		int w;
		w = trip;
		if (w < `PULSE_MIN)
			w = `PULSE_MIN;
		if (w > `PULSE_MAX)
			w = `PULSE_MAX;
		return w;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Coil current model and level monitor
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (!current_limit || pwm !== 1'b1) begin
			high_cycles <= 0;
			coil_current <= '0; // Decays as soon as the drive stops
		end else begin
			high_cycles <= high_cycles + 1;
			if (high_cycles + 1 >= TRIP)
				coil_current <= `SAMPLE_W'(`I_HIGH + 70);
		end
	end

	always @(posedge clk) begin
		if (level_check_en) begin
			exp_levels = expected_levels(iset, cont_n, lt3420_done, fire_button,
				blaster_pkg::KEY_NONE);
			checks++;
			if ({dump, lt3420_charge, arm_led_n, cont_led_n} !== exp_levels) begin
				errors++;
				$display("ERROR %s: expected %b, actual %b", test_name, exp_levels,
					{dump, lt3420_charge, arm_led_n, cont_led_n});
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks and waits
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	function automatic logic output_level(input int sel);
		case (sel)
			SEL_PWM:     output_level = pwm;
			SEL_SPEAKER: output_level = speaker;
			SEL_DUMP:    output_level = dump;
			default:     output_level = lt3420_charge;
		endcase
	endfunction

	// Counts falling edges until the output reaches level
	task automatic wait_for(input int sel, input logic level, input int limit,
			input string what, output int cycles);
		cycles = 0;
		while (output_level(sel) !== level && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (output_level(sel) !== level) begin
			errors++;
			$display("Timed out after %0d cycles waiting for %s", limit, what);
		end
	endtask

	// Output low for quiet cycles in a row
	task automatic wait_quiet(input int sel, input int quiet, input int limit,
			input string what);
		int low_run;
		int cycles;
		low_run = 0;
		cycles = 0;
		while (low_run < quiet && cycles < limit) begin
			@(negedge clk);
			cycles++;
			low_run = (output_level(sel) === 1'b0) ? low_run + 1 : 0;
		end
		if (low_run < quiet) begin
			errors++;
			$display("Timed out after %0d cycles waiting for %s", limit, what);
		end
	endtask

	task automatic measure_train(input string name, input int exp_width, input int tol,
			input int first_limit);
		int cycles;
		int pulses;
		int gap;
		pulses = 0;
		wait_for(SEL_PWM, 1'b1, first_limit, {name, " first pulse"}, cycles);
		while (pwm === 1'b1 && pulses < 8) begin
			pulses++;
			wait_for(SEL_PWM, 1'b0, 2 * `PULSE_MAX, {name, " pulse end"}, cycles);
			checks++;
			if (cycles < exp_width || cycles > exp_width + tol) begin
				errors++;
				$display("ERROR %s width: expected %0d, actual %0d", name, exp_width, cycles);
			end
			gap = 0;
			while (pwm === 1'b0 && gap < 4 * `PULSE_MIN) begin
				@(negedge clk);
				gap++;
			end
			if (pwm === 1'b1)
				check_value({name, " gap"}, `PULSE_MIN + 1, gap);
		end
		check_value({name, " pulse count"}, `PULSE_COUNT, pulses);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		int cycles;
		blaster_pkg::key_code_t k;
		reset = 1'b1;
		fire_button = 1'b0;
		lt3420_done = 1'b0;
		cont_n = 1'b1;
		iset = 3'b111;
		coil_current = '0;
		pressed_key = blaster_pkg::KEY_NONE;
		current_limit = 1'b0;
		level_check_en = 1'b0;
		errors = 0;
		checks = 0;
		rng_state = 338;
		test_name = "reset";
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		level_check_en = 1'b1;
		@(negedge clk);
		check_value("reset pwm", 0, pwm);
		check_value("reset speaker", 0, speaker);
		check_value("reset speaker_n", 1, speaker_n);
		check_value("reset keypad_out", 7'h7F & ~(7'h01 << 1), keypad_out); // Row 0 on pin 1

		test_name = "levels";
		for (int i = 0; i < 20; i++) begin
			r = lcg_next();
			iset = r[2:0];
			cont_n = r[3];
			lt3420_done = r[4];
			fire_button = r[5];
			repeat (2) @(negedge clk);
		end
		level_check_en = 1'b0;
		iset = 3'b111;
		cont_n = 1'b1;
		lt3420_done = 1'b0;
		fire_button = 1'b0;
		wait_quiet(SEL_PWM, TRIG + 100, 10 * TRIG, "pulse generator idle");

		fire_button = 1'b1;
		measure_train("full width", expected_width(NEVER_TRIP), 0, TRIG + 10);
		fire_button = 1'b0;
		wait_quiet(SEL_PWM, 2 * TRIG, 2 * TRIG, "pwm to stay low without a fire request");

		current_limit = 1'b1;
		fire_button = 1'b1;
		measure_train("current limit", expected_width(TRIP), 2, TRIG + 10);
		fire_button = 1'b0;
		current_limit = 1'b0;
		wait_quiet(SEL_PWM, TRIG + 100, 4 * TRIG, "pulse generator idle");

		for (int i = 0; i < 4; i++) begin
			r = lcg_next();
			k = blaster_pkg::key_code_t'(5'h11 + {2'b00, r[2:0]});
			pressed_key = k;
			wait_for(SEL_SPEAKER, 1'b1, KEY_TIMEOUT + 2 * QUIET, "speaker rise", cycles);
			wait_for(SEL_SPEAKER, 1'b0, 2 * QUIET, "speaker fall", cycles);
			check_value($sformatf("tone key %0h half period", k), expected_half_period(k),
				cycles);
			pressed_key = blaster_pkg::KEY_NONE;
			wait_quiet(SEL_SPEAKER, QUIET, KEY_TIMEOUT + 3 * QUIET, "speaker silent");
		end

		// Keypad dump, then keypad charge
		for (int i = 0; i < 2; i++) begin
			k = (i == 0) ? blaster_pkg::KEY_DUMP : blaster_pkg::KEY_CHARGE;
			test_name = (i == 0) ? "dump key" : "charge key";
			pressed_key = k;
			wait_for((i == 0) ? SEL_DUMP : SEL_CHARGE, 1'b1, KEY_TIMEOUT, test_name, cycles);
			check_value(test_name, expected_levels(iset, cont_n, lt3420_done, fire_button, k),
				{dump, lt3420_charge, arm_led_n, cont_led_n});
			pressed_key = blaster_pkg::KEY_NONE;
			wait_for((i == 0) ? SEL_DUMP : SEL_CHARGE, 1'b0, KEY_TIMEOUT, "key release",
				cycles);
		end

		pressed_key = blaster_pkg::KEY_FIRE;
		measure_train("fire key", expected_width(NEVER_TRIP), 0, KEY_TIMEOUT + TRIG);
		pressed_key = blaster_pkg::KEY_NONE;
		wait_quiet(SEL_PWM, TRIG + 100, 6 * FRAME, "pulse generator idle");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* tests/keypad_model.sv */
module keypad_model (
	input  blaster_pkg::key_code_t key,
	input  logic [6:0]             keypad_out,
	output logic [6:0]             keypad_in
);

	timeunit 1ns;
	timeprecision 1ps;

	int pos; // row*3 + col, or -1 with no key

	// Matrix position of each key
	function automatic int key_pos(input blaster_pkg::key_code_t k);
		case (k)
			blaster_pkg::KEY_TONE3:   key_pos = 0;
			blaster_pkg::KEY_TONE2:   key_pos = 1;
			blaster_pkg::KEY_TONE1:   key_pos = 2;
			blaster_pkg::KEY_TONE6:   key_pos = 3;
			blaster_pkg::KEY_TONE5:   key_pos = 4;
			blaster_pkg::KEY_TONE4:   key_pos = 5;
			blaster_pkg::KEY_RESMEAS: key_pos = 6;
			blaster_pkg::KEY_TONE8:   key_pos = 7;
			blaster_pkg::KEY_TONE7:   key_pos = 8;
			blaster_pkg::KEY_DUMP:    key_pos = 9;
			blaster_pkg::KEY_FIRE:    key_pos = 10;
			blaster_pkg::KEY_CHARGE:  key_pos = 11;
			default:                  key_pos = -1;
		endcase
	endfunction

	function automatic int row_pin(input int row);
		case (row)
			0:       row_pin = 1;
			1:       row_pin = 6;
			2:       row_pin = 5;
			default: row_pin = 3;
		endcase
	endfunction

	function automatic int col_pin(input int col);
		case (col)
			0:       col_pin = 4;
			1:       col_pin = 0;
			default: col_pin = 2;
		endcase
	endfunction

	// Pressed switch shorts its column to the driven row
	always_comb begin
		pos = key_pos(key);
		keypad_in = 7'h7F;
		if (pos >= 0 && keypad_out[row_pin(pos / 3)] == 1'b0)
			keypad_in[col_pin(pos % 3)] = 1'b0;
	end

endmodule

/* tests/tb_clock.sv */
module tb_clock (
	output logic clk
);

	timeunit 1ns;
	timeprecision 1ps;

	initial clk = 1'b0;

	always #5 clk = !clk; // 10 ns period

endmodule

/* verilog.f */
+incdir+include
source/blaster_pkg.sv
source/key_scan.sv
source/fire_pulse_gen.sv
source/panel_driver.sv
source/blaster_top.sv
tests/tb_clock.sv
tests/keypad_model.sv
tests/blaster_tb.sv
